// File: include/csr_adapter_settings.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory bus to CSR bus adapter.
// Bus widths and the response info depth.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef CSR_ADAPTER_SETTINGS_SVH
`define CSR_ADAPTER_SETTINGS_SVH

// Byte address width, shared by both buses.
`define CSRA_ADDR_W 16
`define CSRA_ID_W 4

// One CSR access moves one unit.
`define CSRA_UNIT_W 32
`define CSRA_UNITS 4

// Length field holds beats minus one.
`define CSRA_LEN_W 2

// Unit counter, up to 16 units per request.
`define CSRA_COUNT_W 5

// Max outstanding non-posted requests.
`define CSRA_NP_DEPTH 2

`endif

// File: verilog/csr_adapter_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory bus to CSR bus adapter types.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "csr_adapter_settings.svh"

package csr_adapter_pkg;

  typedef enum logic [1:0] {
    MEM_READ     = 2'd0,
    MEM_WRITE    = 2'd1, // Posted.
    MEM_WRITE_NP = 2'd2
  } mem_cmd_e;

  typedef enum logic [1:0] {
    CSR_READ     = 2'd0,
    CSR_WRITE    = 2'd1, // No response.
    CSR_WRITE_NP = 2'd2
  } csr_cmd_e;

  typedef enum logic {
    RESP_DATA = 1'b0,
    RESP_ACK  = 1'b1
  } mem_resp_e;

  typedef struct packed {
    mem_cmd_e                 cmd;
    logic [`CSRA_ID_W-1:0]    id;
    logic [`CSRA_ADDR_W-1:0]  addr;
    logic [`CSRA_LEN_W-1:0]   len;
  } mem_cmd_t;

  typedef struct packed {
    logic [`CSRA_UNITS*`CSRA_UNIT_W-1:0]    data;
    logic [`CSRA_UNITS*`CSRA_UNIT_W/8-1:0]  byteen;
  } mem_wdata_t;

  typedef struct packed {
    mem_resp_e                            kind;
    logic [`CSRA_ID_W-1:0]                id;
    logic [`CSRA_UNITS*`CSRA_UNIT_W-1:0]  data;
    logic                                 error;
    logic                                 last;
  } mem_resp_t;

  typedef struct packed {
    csr_cmd_e                 cmd;
    logic [`CSRA_ADDR_W-1:0]  addr;
    logic [`CSRA_UNIT_W-1:0]  data;
  } csr_cmd_t;

  typedef struct packed {
    logic [`CSRA_UNIT_W-1:0]  data;
    logic                     error;
  } csr_resp_t;

  // One entry per non-posted request, in request order.
  typedef struct packed {
    mem_resp_e                        kind;
    logic [`CSRA_ID_W-1:0]            id;
    logic [$clog2(`CSRA_UNITS)-1:0]   unit_offset;
    logic [`CSRA_COUNT_W-1:0]         unit_count;  // CSR responses to expect.
    logic                             ignore;
  } resp_info_t;

endpackage

// File: verilog/response_info_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Response info FIFO, register ring.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "csr_adapter_settings.svh"

module response_info_fifo
  import csr_adapter_pkg::*;
#(
  parameter int  DEPTH   = `CSRA_NP_DEPTH,
  parameter type entry_t = resp_info_t
)(
  input  logic   i_clk,
  input  logic   i_rst_n,
  input  logic   i_push,
  input  entry_t i_data,
  input  logic   i_pop,
  output entry_t o_data,
  output logic   o_empty,
  output logic   o_full
);

  localparam int PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int COUNT_W = $clog2(DEPTH + 1);

  entry_t             ring [DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [COUNT_W-1:0] count;
  logic               do_push;
  logic               do_pop;

  function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
  endfunction

  always_comb begin
    o_empty = count == '0;
    o_full  = count == COUNT_W'(DEPTH);
    do_push = i_push && !o_full;
    do_pop  = i_pop && !o_empty;
    o_data  = ring[rd_ptr];
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= next_ptr(wr_ptr);
      if (do_pop) rd_ptr <= next_ptr(rd_ptr);
      count <= count + COUNT_W'(do_push) - COUNT_W'(do_pop);
    end
  end

  always_ff @(posedge i_clk) begin
    if (do_push) begin
      ring[wr_ptr] <= i_data;
    end
  end

endmodule

// File: verilog/unit_request_splitter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Request splitter. Walks a memory-bus
// request one unit at a time on the CSR bus.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "csr_adapter_settings.svh"

module unit_request_splitter
  import csr_adapter_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_rst_n,
  input  logic       i_force_np_write,
  input  logic       i_mem_cmd_valid,
  output logic       o_mem_cmd_accept,
  input  mem_cmd_t   i_mem_cmd,
  input  logic       i_mem_wdata_valid,
  output logic       o_mem_wdata_accept,
  input  mem_wdata_t i_mem_wdata,
  output logic       o_csr_cmd_valid,
  input  logic       i_csr_cmd_accept,
  output csr_cmd_t   o_csr_cmd,
  input  logic       i_info_full,
  output logic       o_info_push,
  output resp_info_t o_info
);

  localparam int UNIT_W   = `CSRA_UNIT_W;
  localparam int BYTES    = `CSRA_UNIT_W / 8;
  localparam int LSB      = $clog2(BYTES);
  localparam int OFFSET_W = $clog2(`CSRA_UNITS);
  localparam int WADDR_W  = `CSRA_ADDR_W - LSB;
  localparam int COUNT_W  = `CSRA_COUNT_W;

  logic                busy;
  logic                force_q;
  logic [COUNT_W-1:0]  remain_q;
  logic [OFFSET_W-1:0] lane_q;
  logic [WADDR_W-1:0]  waddr_q;
  logic [COUNT_W-1:0]  rsp_q;

  logic                force_cur;
  logic [COUNT_W-1:0]  remain_cur;
  logic [OFFSET_W-1:0] lane_cur;
  logic [WADDR_W-1:0]  waddr_cur;
  logic [COUNT_W-1:0]  rsp_cur;
  logic [COUNT_W-1:0]  rsp_next;
  csr_cmd_e            csr_cmd;
  logic                is_read;
  logic                is_write;
  logic                non_posted;
  logic                np_ready;
  logic                unit_en;
  logic                last_unit;
  logic                lane_last;
  logic                cmd_go;
  logic                step;

  // First unit comes straight from the command.
  always_comb begin
    if (busy) begin
      force_cur  = force_q;
      lane_cur   = lane_q;
      waddr_cur  = waddr_q;
      remain_cur = remain_q;
      rsp_cur    = rsp_q;
    end else begin
      force_cur  = i_force_np_write;
      lane_cur   = i_mem_cmd.addr[LSB+:OFFSET_W];
      waddr_cur  = i_mem_cmd.addr[LSB+:WADDR_W];
      remain_cur = ((COUNT_W'(i_mem_cmd.len) + COUNT_W'(1)) << OFFSET_W)
                   - COUNT_W'(i_mem_cmd.addr[LSB+:OFFSET_W]);
      rsp_cur    = '0;
    end
  end

  always_comb begin
    case (i_mem_cmd.cmd)
      MEM_READ:     csr_cmd = CSR_READ;
      MEM_WRITE_NP: csr_cmd = CSR_WRITE_NP;
      default:      csr_cmd = force_cur ? CSR_WRITE_NP : CSR_WRITE;
    endcase
  end

  always_comb begin
    is_read    = i_mem_cmd.cmd == MEM_READ;
    is_write   = i_mem_cmd.cmd inside {MEM_WRITE, MEM_WRITE_NP};
    non_posted = csr_cmd != CSR_WRITE;
    np_ready   = !non_posted || busy || !i_info_full; // Room for the info entry.
    unit_en    = |i_mem_wdata.byteen[lane_cur*BYTES+:BYTES];
    last_unit  = remain_cur == COUNT_W'(1);
    lane_last  = lane_cur == '1;

    cmd_go          = i_mem_cmd_valid && np_ready && (is_read || (is_write && i_mem_wdata_valid));
    o_csr_cmd_valid = cmd_go && (is_read || unit_en);
    // Empty write units advance without a CSR access.
    step            = cmd_go && (o_csr_cmd_valid ? i_csr_cmd_accept : 1'b1);

    o_mem_cmd_accept   = step && last_unit;
    o_mem_wdata_accept = step && is_write && (lane_last || last_unit);
  end

  always_comb begin
    o_csr_cmd.cmd  = csr_cmd;
    o_csr_cmd.addr = {waddr_cur, LSB'(0)};
    o_csr_cmd.data = i_mem_wdata.data[lane_cur*UNIT_W+:UNIT_W];
  end

  // Responses expected from this request, current access included.
  always_comb begin
    rsp_next = rsp_cur + COUNT_W'(o_csr_cmd_valid && i_csr_cmd_accept && non_posted);

    o_info_push        = step && last_unit && non_posted;
    o_info.kind        = is_read ? RESP_DATA : RESP_ACK;
    o_info.id          = i_mem_cmd.id;
    o_info.unit_offset = i_mem_cmd.addr[LSB+:OFFSET_W];
    o_info.unit_count  = rsp_next;
    o_info.ignore      = force_cur && (i_mem_cmd.cmd == MEM_WRITE);
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      busy     <= 1'b0;
      force_q  <= 1'b0;
      remain_q <= '0;
      lane_q   <= '0;
      waddr_q  <= '0;
      rsp_q    <= '0;
    end else if (step) begin
      busy     <= !last_unit;
      force_q  <= force_cur;
      remain_q <= remain_cur - COUNT_W'(1);
      lane_q   <= lane_cur + OFFSET_W'(1);
      waddr_q  <= waddr_cur + WADDR_W'(1); // Word addresses count upward.
      rsp_q    <= rsp_next;
    end
  end

endmodule

// File: verilog/response_assembler.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Response assembler. Packs CSR responses
// into memory-bus response beats.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "csr_adapter_settings.svh"

module response_assembler
  import csr_adapter_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_rst_n,
  input  resp_info_t i_info,
  input  logic       i_info_empty,
  output logic       o_info_pop,
  input  logic       i_csr_resp_valid,
  output logic       o_csr_resp_accept,
  input  csr_resp_t  i_csr_resp,
  output logic       o_mem_resp_valid,
  input  logic       i_mem_resp_accept,
  output mem_resp_t  o_mem_resp
);

  localparam int UNITS    = `CSRA_UNITS;
  localparam int UNIT_W   = `CSRA_UNIT_W;
  localparam int OFFSET_W = $clog2(`CSRA_UNITS);
  localparam int COUNT_W  = `CSRA_COUNT_W;

  logic                         busy;
  logic [COUNT_W-1:0]           count_q;
  logic [OFFSET_W-1:0]          lane_q;
  logic                         error_q;
  logic [UNITS-2:0][UNIT_W-1:0] lane_data_q;

  logic [COUNT_W-1:0]           count_cur;
  logic [OFFSET_W-1:0]          lane_cur;
  logic                         no_resp;
  logic                         last_resp;
  logic                         beat_end;
  logic                         csr_fire;
  logic [UNITS-1:0][UNIT_W-1:0] beat_data;

  always_comb begin
    count_cur = busy ? count_q : '0;
    lane_cur  = busy ? lane_q : i_info.unit_offset;
    no_resp   = i_info.unit_count == '0;
    last_resp = (count_cur + COUNT_W'(1)) == i_info.unit_count;
    // A read beat closes at the top lane, an ack only at the end.
    beat_end  = last_resp || ((i_info.kind == RESP_DATA) && (lane_cur == '1));
  end

  always_comb begin
    if (i_info_empty) begin
      o_csr_resp_accept = 1'b0; // Hold responses until the entry arrives.
      o_mem_resp_valid  = 1'b0;
    end else if (no_resp) begin
      o_csr_resp_accept = 1'b0;
      o_mem_resp_valid  = !i_info.ignore;
    end else if (i_info.ignore || !beat_end) begin
      o_csr_resp_accept = 1'b1;
      o_mem_resp_valid  = 1'b0;
    end else begin
      o_csr_resp_accept = i_mem_resp_accept;
      o_mem_resp_valid  = i_csr_resp_valid;
    end

    csr_fire   = i_csr_resp_valid && o_csr_resp_accept;
    o_info_pop = (csr_fire && last_resp)
                 || (!i_info_empty && no_resp && (i_info.ignore || i_mem_resp_accept));
  end

  // Current lane bypasses its register.
  always_comb begin
    for (int i = 0; i < UNITS - 1; i++) begin
      beat_data[i] = (lane_cur == OFFSET_W'(i)) ? i_csr_resp.data : lane_data_q[i];
    end
    beat_data[UNITS-1] = i_csr_resp.data;
  end

  always_comb begin
    o_mem_resp.kind  = i_info.kind;
    o_mem_resp.id    = i_info.id;
    o_mem_resp.data  = beat_data;
    o_mem_resp.error = error_q || (!no_resp && i_csr_resp.error);
    o_mem_resp.last  = last_resp || no_resp;
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      busy    <= 1'b0;
      count_q <= '0;
      lane_q  <= '0;
      error_q <= 1'b0;
    end else if (csr_fire) begin
      busy    <= !last_resp;
      count_q <= count_cur + COUNT_W'(1);
      lane_q  <= lane_cur + OFFSET_W'(1);
      error_q <= beat_end ? 1'b0 : (error_q | i_csr_resp.error); // Per beat.
    end
  end

  always_ff @(posedge i_clk) begin
    if (csr_fire && (lane_cur != '1)) begin
      lane_data_q[lane_cur] <= i_csr_resp.data;
    end
  end

endmodule

// File: verilog/membus_csr_adapter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory bus to CSR bus adapter.
// Splits wide requests into unit accesses.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "csr_adapter_settings.svh"

module membus_csr_adapter
  import csr_adapter_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_rst_n,
  input  logic       i_force_np_write,
  input  logic       i_mem_cmd_valid,
  output logic       o_mem_cmd_accept,
  input  mem_cmd_t   i_mem_cmd,
  input  logic       i_mem_wdata_valid,
  output logic       o_mem_wdata_accept,
  input  mem_wdata_t i_mem_wdata,
  output logic       o_mem_resp_valid,
  input  logic       i_mem_resp_accept,
  output mem_resp_t  o_mem_resp,
  output logic       o_csr_cmd_valid,
  input  logic       i_csr_cmd_accept,
  output csr_cmd_t   o_csr_cmd,
  input  logic       i_csr_resp_valid,
  output logic       o_csr_resp_accept,
  input  csr_resp_t  i_csr_resp
);

  logic       info_full;
  logic       info_empty;
  logic       info_push;
  logic       info_pop;
  resp_info_t info_in;
  resp_info_t info_out;

  unit_request_splitter splitter_i (
    .i_clk              (i_clk),
    .i_rst_n            (i_rst_n),
    .i_force_np_write   (i_force_np_write),
    .i_mem_cmd_valid    (i_mem_cmd_valid),
    .o_mem_cmd_accept   (o_mem_cmd_accept),
    .i_mem_cmd          (i_mem_cmd),
    .i_mem_wdata_valid  (i_mem_wdata_valid),
    .o_mem_wdata_accept (o_mem_wdata_accept),
    .i_mem_wdata        (i_mem_wdata),
    .o_csr_cmd_valid    (o_csr_cmd_valid),
    .i_csr_cmd_accept   (i_csr_cmd_accept),
    .o_csr_cmd          (o_csr_cmd),
    .i_info_full        (info_full),
    .o_info_push        (info_push),
    .o_info             (info_in)
  );

  response_info_fifo #(
    .DEPTH   (`CSRA_NP_DEPTH),
    .entry_t (resp_info_t)
  ) info_fifo_i (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_push  (info_push),
    .i_data  (info_in),
    .i_pop   (info_pop),
    .o_data  (info_out),
    .o_empty (info_empty),
    .o_full  (info_full)
  );

  response_assembler assembler_i (
    .i_clk             (i_clk),
    .i_rst_n           (i_rst_n),
    .i_info            (info_out),
    .i_info_empty      (info_empty),
    .o_info_pop        (info_pop),
    .i_csr_resp_valid  (i_csr_resp_valid),
    .o_csr_resp_accept (o_csr_resp_accept),
    .i_csr_resp        (i_csr_resp),
    .o_mem_resp_valid  (o_mem_resp_valid),
    .i_mem_resp_accept (i_mem_resp_accept),
    .o_mem_resp        (o_mem_resp)
  );

endmodule

// File: dv/csr_target_model.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CSR target model. Word memory with an
// error region and random stalls.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "csr_adapter_settings.svh"

module csr_target_model
  import csr_adapter_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst_n,
  input  logic      i_cmd_valid,
  output logic      o_cmd_accept,
  input  csr_cmd_t  i_cmd,
  output logic      o_resp_valid,
  input  logic      i_resp_accept,
  output csr_resp_t o_resp
);

  timeunit 1ns;
  timeprecision 100ps;

  logic [`CSRA_UNIT_W-1:0] mem [256];
  csr_resp_t               pending [$]; // Responses owed, oldest first.
  logic                    err;

  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = {8'hc5, 8'(i), ~8'(i), 8'(i) ^ 8'h5a};
    end
  end

  always @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_cmd_accept <= 1'b0;
      o_resp_valid <= 1'b0;
      o_resp       <= '0;
      pending.delete();
    end else begin
      if (i_cmd_valid && o_cmd_accept) begin
        err = i_cmd.addr[15]; // Upper half of the map is the error region.
        if (i_cmd.cmd != CSR_READ && !err) begin
          mem[i_cmd.addr[9:2]] <= i_cmd.data;
        end
        if (i_cmd.cmd == CSR_READ) begin
          pending.push_back('{data: mem[i_cmd.addr[9:2]], error: err});
        end else if (i_cmd.cmd == CSR_WRITE_NP) begin
          pending.push_back('{data: '0, error: err});
        end
      end
      if (o_resp_valid && i_resp_accept) begin
        pending.delete(0);
      end
      // A response once shown stays until it is taken.
      if (!o_resp_valid || i_resp_accept) begin
        o_resp_valid <= (pending.size() != 0) && ($urandom_range(0, 2) != 0);
        if (pending.size() != 0) begin
          o_resp <= pending[0];
        end
      end
      o_cmd_accept <= $urandom_range(0, 2) != 0;
    end
  end

endmodule

// File: dv/membus_csr_adapter_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the memory bus to CSR
// adapter, with a behavioral CSR target.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "csr_adapter_settings.svh"

module membus_csr_adapter_tb
  import csr_adapter_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int DATA_W  = `CSRA_UNITS * `CSRA_UNIT_W;
  localparam int TIMEOUT = 40 * 300; // Transactions times cycles each.

  logic       clk = 1'b0;
  logic       rst_n;
  logic       force_np;
  logic       mem_cmd_valid;
  logic       mem_cmd_accept;
  mem_cmd_t   mem_cmd;
  logic       mem_wdata_valid;
  logic       mem_wdata_accept;
  mem_wdata_t mem_wdata;
  logic       mem_resp_valid;
  logic       mem_resp_accept;
  mem_resp_t  mem_resp;
  logic       csr_cmd_valid;
  logic       csr_cmd_accept;
  csr_cmd_t   csr_cmd;
  logic       csr_resp_valid;
  logic       csr_resp_accept;
  csr_resp_t  csr_resp;

  logic [`CSRA_UNIT_W-1:0] shadow [256];
  mem_wdata_t              wbeats [4];
  mem_resp_t               exp_q [$];
  logic [DATA_W-1:0]       mask_q [$];
  string                   name_q [$];
  mem_resp_t               exp_resp;
  logic [DATA_W-1:0]       exp_mask;
  string                   exp_name;
  logic [`CSRA_ID_W-1:0]   txn_id = '0;
  int                      value_errors = 0;
  int                      other_errors = 0;
  int                      checked = 0;
  int                      cycles = 0;

  membus_csr_adapter membus_csr_adapter_i (
    .i_clk              (clk),
    .i_rst_n            (rst_n),
    .i_force_np_write   (force_np),
    .i_mem_cmd_valid    (mem_cmd_valid),
    .o_mem_cmd_accept   (mem_cmd_accept),
    .i_mem_cmd          (mem_cmd),
    .i_mem_wdata_valid  (mem_wdata_valid),
    .o_mem_wdata_accept (mem_wdata_accept),
    .i_mem_wdata        (mem_wdata),
    .o_mem_resp_valid   (mem_resp_valid),
    .i_mem_resp_accept  (mem_resp_accept),
    .o_mem_resp         (mem_resp),
    .o_csr_cmd_valid    (csr_cmd_valid),
    .i_csr_cmd_accept   (csr_cmd_accept),
    .o_csr_cmd          (csr_cmd),
    .i_csr_resp_valid   (csr_resp_valid),
    .o_csr_resp_accept  (csr_resp_accept),
    .i_csr_resp         (csr_resp)
  );

  csr_target_model csr_target_i (
    .i_clk         (clk),
    .i_rst_n       (rst_n),
    .i_cmd_valid   (csr_cmd_valid),
    .o_cmd_accept  (csr_cmd_accept),
    .i_cmd         (csr_cmd),
    .o_resp_valid  (csr_resp_valid),
    .i_resp_accept (csr_resp_accept),
    .o_resp        (csr_resp)
  );

  always #10 clk = ~clk;

  always @(posedge clk) mem_resp_accept <= $urandom_range(0, 3) != 0; // Random stalls.

  // Word address of unit k, counted from lane 0 of the first beat.
  function automatic logic [13:0] word_addr(input logic [15:0] addr, input int k);
    return addr[15:2] + 14'(k - int'(addr[3:2]));
  endfunction

  function automatic logic [15:0] rand_addr(input logic err_region);
    logic [15:0] a;
    a = 16'($urandom) & 16'h03f0;
    a[3:2] = 2'($urandom_range(1, 3)); // Never lane aligned.
    a[15] = err_region;
    return a;
  endfunction

  function automatic mem_resp_t predict(input mem_cmd_t c, input int beat,
                                        output logic [DATA_W-1:0] mask);
    mem_resp_t   r;
    logic [13:0] wa;
    int          k;
    r = '0;
    mask = '0;
    r.id = c.id;
    if (c.cmd == MEM_READ) begin
      r.kind = RESP_DATA;
      r.last = beat == int'(c.len);
      for (k = (beat == 0) ? int'(c.addr[3:2]) : 0; k < 4; k++) begin
        wa = word_addr(c.addr, 4 * beat + k);
        r.data[k*32+:32] = shadow[wa[7:0]];
        r.error |= wa[13];
        mask[k*32+:32] = '1;
      end
    end else begin
      // One ack for every unit that reached the CSR bus.
      r.kind = RESP_ACK;
      r.last = 1'b1;
      for (k = int'(c.addr[3:2]); k < 4 * (int'(c.len) + 1); k++) begin
        wa = word_addr(c.addr, k);
        if (|wbeats[k/4].byteen[(k%4)*4+:4]) r.error |= wa[13];
      end
    end
    return r;
  endfunction

  task automatic check_resp_kind(input string name, input mem_resp_e exp, input mem_resp_e act);
    if (act !== exp) begin
      value_errors++;
      $display("FAILED %s kind: expected %s, actual %s", name, exp.name(), act.name());
    end
  endtask

  task automatic check_resp_id(input string name, input logic [`CSRA_ID_W-1:0] exp,
                               input logic [`CSRA_ID_W-1:0] act);
    if (act !== exp) begin
      value_errors++;
      $display("FAILED %s id: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_resp_data(input string name, input logic [DATA_W-1:0] exp,
                                 input logic [DATA_W-1:0] act, input logic [DATA_W-1:0] mask);
    if ((act & mask) !== (exp & mask)) begin
      value_errors++;
      $display("FAILED %s data: expected %h, actual %h", name, exp & mask, act & mask);
    end
  endtask

  task automatic check_resp_flags(input string name, input logic exp_error, input logic exp_last,
                                  input logic act_error, input logic act_last);
    if (act_error !== exp_error || act_last !== exp_last) begin
      value_errors++;
      $display("FAILED %s flags: expected error %b last %b, actual error %b last %b",
               name, exp_error, exp_last, act_error, act_last);
    end
  endtask

  always @(negedge clk) begin
    if (rst_n && mem_resp_valid && mem_resp_accept) begin
      if (exp_q.size() == 0) begin
        other_errors++;
        $display("A response with ID %0d arrived when none was expected.", mem_resp.id);
      end else begin
        exp_resp = exp_q.pop_front();
        exp_mask = mask_q.pop_front();
        exp_name = name_q.pop_front();
        check_resp_kind(exp_name, exp_resp.kind, mem_resp.kind);
        check_resp_id(exp_name, exp_resp.id, mem_resp.id);
        check_resp_data(exp_name, exp_resp.data, mem_resp.data, exp_mask);
        check_resp_flags(exp_name, exp_resp.error, exp_resp.last, mem_resp.error, mem_resp.last);
        checked++;
      end
    end
  end

  task automatic finish_run();
    $display("Errors: %0d wrong values, %0d other; %0d responses checked.",
             value_errors, other_errors, checked);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles == TIMEOUT) begin
      other_errors++;
      $display("The run did not finish within %0d cycles, %0d responses still outstanding.",
               TIMEOUT, exp_q.size());
      finish_run();
    end
  end

  // Enable modes: 0 every unit on, 1 about half off, 2 all off.
  task automatic run_txn(input string name, input mem_cmd_e cmd, input logic [15:0] addr,
                         input int len, input logic force_in, input int en_mode);
    mem_cmd_t          c;
    mem_resp_t         r;
    logic [DATA_W-1:0] mask;
    logic [13:0]       wa;
    logic              cmd_done;
    logic              beat_done;
    int                beat;
    int                k;
    c = '{cmd: cmd, id: txn_id, addr: addr, len: 2'(len)};
    txn_id++;
    for (k = 0; k < 16; k++) begin
      wbeats[k/4].data[(k%4)*32+:32] = $urandom;
      if (en_mode == 2 || (en_mode == 1 && $urandom_range(0, 1) == 0))
        wbeats[k/4].byteen[(k%4)*4+:4] = 4'h0;
      else
        wbeats[k/4].byteen[(k%4)*4+:4] = 4'($urandom_range(1, 15));
    end
    if (cmd == MEM_READ || cmd == MEM_WRITE_NP) begin
      for (beat = 0; beat <= ((cmd == MEM_READ) ? len : 0); beat++) begin
        r = predict(c, beat, mask);
        exp_q.push_back(r);
        mask_q.push_back(mask);
        name_q.push_back(name);
      end
    end
    if (cmd != MEM_READ) begin
      for (k = int'(addr[3:2]); k < 4 * (len + 1); k++) begin
        wa = word_addr(addr, k);
        if (|wbeats[k/4].byteen[(k%4)*4+:4] && !wa[13])
          shadow[wa[7:0]] = wbeats[k/4].data[(k%4)*32+:32];
      end
    end
    @(posedge clk);
    mem_cmd_valid   <= 1'b1;
    mem_cmd         <= c;
    force_np        <= force_in;
    mem_wdata_valid <= cmd != MEM_READ;
    mem_wdata       <= wbeats[0];
    beat = 0;
    cmd_done = 1'b0;
    while (!cmd_done) begin
      @(negedge clk);
      cmd_done  = mem_cmd_valid && mem_cmd_accept;
      beat_done = mem_wdata_valid && mem_wdata_accept;
      @(posedge clk);
      if (beat_done) begin
        beat++;
        mem_wdata <= wbeats[beat % 4];
      end
      if (cmd_done) begin
        mem_cmd_valid   <= 1'b0;
        mem_wdata_valid <= 1'b0;
      end
    end
    if (cmd != MEM_READ && beat != len + 1) begin
      other_errors++;
      $display("%s took %0d write beats for a %0d beat request.", name, beat, len + 1);
    end
  endtask

  initial begin
    int          i;
    int          l;
    logic [15:0] a;
    void'($urandom(32'h3e9a_6403));
    for (i = 0; i < 256; i++)
      shadow[i] = {8'hc5, 8'(i), ~8'(i), 8'(i) ^ 8'h5a};
    rst_n           <= 1'b0;
    force_np        <= 1'b0;
    mem_cmd_valid   <= 1'b0;
    mem_cmd         <= '0;
    mem_wdata_valid <= 1'b0;
    mem_wdata       <= '0;
    mem_resp_accept <= 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    for (l = 0; l < 4; l++) begin
      a = rand_addr(1'b0);
      run_txn("posted_rw", MEM_WRITE, a, l, 1'b0, 0);
      run_txn("posted_rw", MEM_READ, a, l, 1'b0, 0);
    end
    for (i = 0; i < 2; i++) begin
      a = rand_addr(1'b0);
      run_txn("skip_units", MEM_WRITE, a, 3, 1'b0, 1);
      run_txn("skip_units", MEM_READ, a, 3, 1'b0, 0);
    end
    for (i = 0; i < 3; i++)
      run_txn("np_write", MEM_WRITE_NP, rand_addr(1'b0), $urandom_range(0, 3), 1'b0, 1);
    a = rand_addr(1'b0);
    run_txn("np_write_empty", MEM_WRITE_NP, a, 1, 1'b0, 2);
    run_txn("np_write_empty", MEM_READ, a, 1, 1'b0, 0);
    for (i = 0; i < 2; i++) begin
      a = rand_addr(1'b0);
      l = $urandom_range(0, 3);
      run_txn("forced_write", MEM_WRITE, a, l, 1'b1, 0);
      run_txn("forced_write", MEM_READ, a, l, 1'b0, 0);
    end
    a = rand_addr(1'b1);
    run_txn("error_region", MEM_WRITE, a, 1, 1'b0, 0);
    run_txn("error_region", MEM_READ, a, 1, 1'b0, 0);
    run_txn("error_region", MEM_WRITE_NP, a, 0, 1'b0, 0);
    run_txn("error_region", MEM_READ, a, 0, 1'b0, 0);
    for (i = 0; i < 12; i++) begin
      l = $urandom_range(0, 3);
      a = rand_addr($urandom_range(0, 3) == 0);
      case ($urandom_range(0, 2))
        0:       run_txn("random_mix", MEM_READ, a, l, 1'b0, 0);
        1:       run_txn("random_mix", MEM_WRITE, a, l, 1'($urandom_range(0, 1)), 1);
        default: run_txn("random_mix", MEM_WRITE_NP, a, l, 1'b0, 1);
      endcase
    end

    while (exp_q.size() != 0)
      @(posedge clk);
    repeat (20) @(posedge clk); // Room for a stray extra response.
    finish_run();
  end

endmodule

// File: membus_csr_adapter.f
+incdir+include
verilog/csr_adapter_pkg.sv
verilog/response_info_fifo.sv
verilog/unit_request_splitter.sv
verilog/response_assembler.sv
verilog/membus_csr_adapter.sv
dv/csr_target_model.sv
dv/membus_csr_adapter_tb.sv
